//--- Bender.yml
package:
  name: ecs_merge

sources:
  - files:
      - source/ecs_pkg.sv
      - source/ecs_bit_packer.sv
      - source/ecs_word_fifo.sv
      - source/ecs_yuv_arbiter.sv
      - source/ecs_merge.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/ecs_merge_chk.sv
      - test/ecs_merge_tb.sv

//--- flist.f
+incdir+include
source/ecs_pkg.sv
source/ecs_bit_packer.sv
source/ecs_word_fifo.sv
source/ecs_yuv_arbiter.sv
source/ecs_merge.sv
test/ecs_merge_chk.sv
test/ecs_merge_tb.sv

//--- source/ecs_bit_packer.sv
`timescale 1ns/1ps
`default_nettype none

module ecs_bit_packer (
  input  logic               clk,
  input  logic               rstn,
  input  logic               sym_valid,  // one symbol this cycle
  input  ecs_pkg::huff_sym_t sym,
  output logic               word_wr,    // write strobe into the word fifo
  output ecs_pkg::ecs_word_t word
);

  import ecs_pkg::*;

  localparam int pos_w = WLEN_W - 1;  // pointer bits that address a word

  logic [BUF_W-1:0]  code_buf;     // 64 bit word on top, spill-over below
  logic [BUF_W-1:0]  sym_shift;    // symbol placed at the pointer, ones elsewhere
  logic [BUF_W-1:0]  spill;        // spill-over moved up after a full word
  logic [WLEN_W-1:0] bit_ptr;      // msb toggles once per full word
  logic [WLEN_W-1:0] bit_ptr_nxt;
  logic              ptr_ov;       // top word of code_buf is complete
  logic              ptr_ov_nxt;
  logic              sym_eob;
  logic              eob_d1;       // eob lined up with code_buf
  logic              eob_tail;     // eob left bits below the flushed word
  logic              eob_tail_d;   // tail word goes out this cycle
  logic [WLEN_W-1:0] tail_len;     // bits left over by the eob symbol
  logic [WLEN_W-1:0] code_len;     // len of the word being written
  logic [TAIL_W-1:0] tail_code;    // spill-over held for the tail word

  assign sym_eob     = sym_valid & sym.eob;
  assign bit_ptr_nxt = bit_ptr + WLEN_W'(sym.len);
  assign ptr_ov_nxt  = bit_ptr_nxt[WLEN_W-1] ^ bit_ptr[WLEN_W-1];
  assign spill       = {code_buf[TAIL_W-1:0], {WORD_W{1'b1}}};

  // ----------------------------------------------------------
  // six stage shifter, right shift by bit_ptr filling with ones
  // ----------------------------------------------------------
  always_comb begin
    sym_shift = {sym.code, {(BUF_W - HUFF_W){1'b1}}};  // pointer 0 = msb of the word
    for (int k = pos_w - 1; k >= 0; k--) begin
      if (bit_ptr[k]) begin
        sym_shift = ~(~sym_shift >> (1 << k));  // ones shift in from the top
      end
    end
  end

  // packing buffer, zero bits of the symbol clear buffer bits
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      code_buf <= '1;
    end else if (eob_d1) begin
      code_buf <= sym_valid ? sym_shift : '1;  // fresh segment from all ones
    end else if (ptr_ov) begin
      code_buf <= sym_valid ? (spill & sym_shift) : spill;
    end else if (sym_valid) begin
      code_buf <= code_buf & sym_shift;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      bit_ptr    <= '0;
      ptr_ov     <= 1'b0;
      eob_d1     <= 1'b0;
      eob_tail_d <= 1'b0;
    end else begin
      if (sym_valid) begin
        bit_ptr <= sym.eob ? '0 : bit_ptr_nxt;  // eob restarts at the word msb
      end
      ptr_ov     <= sym_valid & ptr_ov_nxt;
      eob_d1     <= sym_eob;
      eob_tail_d <= eob_tail;
    end
  end

  // eob crossed the boundary and something is still left below it
  assign eob_tail = eob_d1 & ptr_ov & (tail_len != '0);

  // ----------------------------------------------------------
  // word length and tail capture
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (sym_eob && ptr_ov_nxt) begin
      tail_len <= {1'b0, bit_ptr_nxt[pos_w-1:0]};
    end
  end

  always_ff @(posedge clk) begin
    if (eob_tail) begin
      code_len <= tail_len;
    end else if (sym_valid) begin
      if (ptr_ov_nxt) begin
        code_len <= WLEN_W'(WORD_W);  // full word, also an exact 64 bit eob
      end else if (sym.eob) begin
        code_len <= {~(|bit_ptr_nxt[pos_w-1:0]), bit_ptr_nxt[pos_w-1:0]};
      end
    end
  end

  always_ff @(posedge clk) begin
    if (eob_tail) begin
      tail_code <= code_buf[TAIL_W-1:0];  // code_buf is cleared in this cycle
    end
  end

  // ----------------------------------------------------------
  // word out to the fifo
  // ----------------------------------------------------------
  assign word_wr   = ptr_ov | eob_d1 | eob_tail_d;
  assign word.eob  = (eob_d1 & ~eob_tail) | eob_tail_d;  // eob moves to the tail
  assign word.len  = code_len;
  assign word.code = eob_tail_d ? {tail_code, {(WORD_W - TAIL_W){1'b1}}}
                                : code_buf[BUF_W-1 -: WORD_W];

endmodule

`default_nettype wire

//--- source/ecs_merge.sv
`timescale 1ns/1ps
`default_nettype none

module ecs_merge #(
  parameter int fifo_depth = 8  // words buffered per channel
) (
  input  logic               clk,
  input  logic               rstn,
  input  logic               y_valid,
  input  logic               u_valid,
  input  logic               v_valid,
  input  ecs_pkg::huff_sym_t y_sym,
  input  ecs_pkg::huff_sym_t u_sym,
  input  ecs_pkg::huff_sym_t v_sym,
  output logic               out_valid,
  output ecs_pkg::ecs_word_t out_word
);

  import ecs_pkg::*;

  // per channel signals, index 0/1/2 = y/u/v as in chan_sel_t
  logic      sym_valid  [3];
  huff_sym_t sym        [3];
  logic      word_wr    [3];
  ecs_word_t word       [3];
  logic      fifo_rd    [3];
  logic      fifo_empty [3];
  ecs_word_t fifo_head  [3];

  assign sym_valid[0] = y_valid;
  assign sym_valid[1] = u_valid;
  assign sym_valid[2] = v_valid;
  assign sym[0]       = y_sym;
  assign sym[1]       = u_sym;
  assign sym[2]       = v_sym;

  // ----------------------------------------------------------
  // packer and word buffer per channel
  // ----------------------------------------------------------
  for (genvar c = 0; c < 3; c++) begin : g_chan
    ecs_bit_packer packer_i (
      .clk       (clk),
      .rstn      (rstn),
      .sym_valid (sym_valid[c]),
      .sym       (sym[c]),
      .word_wr   (word_wr[c]),
      .word      (word[c])
    );

    ecs_word_fifo #(
      .fifo_depth (fifo_depth)
    ) fifo_i (
      .clk   (clk),
      .rstn  (rstn),
      .wr    (word_wr[c]),
      .din   (word[c]),
      .rd    (fifo_rd[c]),
      .dout  (fifo_head[c]),
      .empty (fifo_empty[c])
    );
  end

  ecs_yuv_arbiter arbiter_i (
    .clk       (clk),
    .rstn      (rstn),
    .y_empty   (fifo_empty[0]),
    .u_empty   (fifo_empty[1]),
    .v_empty   (fifo_empty[2]),
    .y_head    (fifo_head[0]),
    .u_head    (fifo_head[1]),
    .v_head    (fifo_head[2]),
    .y_rd      (fifo_rd[0]),
    .u_rd      (fifo_rd[1]),
    .v_rd      (fifo_rd[2]),
    .out_valid (out_valid),
    .out_word  (out_word)
  );

endmodule

`default_nettype wire

//--- source/ecs_pkg.sv
`default_nettype none

package ecs_pkg;

  // ----------------------------------------------------------
  // widths
  // ----------------------------------------------------------
  localparam int HUFF_W = 27;               // input code field
  localparam int HLEN_W = 5;                // input length field, 1..27
  localparam int WORD_W = 64;               // packed output word
  localparam int WLEN_W = 7;                // output bit count, 1..64
  localparam int TAIL_W = 26;               // spill-over part of the packing buffer
  localparam int BUF_W  = WORD_W + TAIL_W;  // 90 bit packing buffer

  // one huffman symbol, code left aligned and padded with ones
  typedef struct packed {
    logic [HUFF_W-1:0] code;
    logic [HLEN_W-1:0] len;   // valid bits in code
    logic              eob;   // last symbol of the segment
  } huff_sym_t;

  // one packed word as stored in the fifo and sent out
  typedef struct packed {
    logic              eob;   // last word of the segment
    logic [WLEN_W-1:0] len;   // valid bits, msb first
    logic [WORD_W-1:0] code;
  } ecs_word_t;

  // channel rotation, encoding doubles as the channel index
  typedef enum logic [1:0] {
    chan_y = 2'd0,
    chan_u = 2'd1,
    chan_v = 2'd2
  } chan_sel_t;

  // y -> u -> v -> y
  function automatic chan_sel_t next_chan(chan_sel_t cur);
    case (cur)
      chan_y:  return chan_u;
      chan_u:  return chan_v;
      default: return chan_y;  // v and the unused code fall back to y
    endcase
  endfunction

endpackage

`default_nettype wire

//--- source/ecs_word_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module ecs_word_fifo #(
  parameter int fifo_depth = 8
) (
  input  logic               clk,
  input  logic               rstn,
  input  logic               wr,
  input  ecs_pkg::ecs_word_t din,
  input  logic               rd,     // ignored while empty
  output ecs_pkg::ecs_word_t dout,   // registered head word
  output logic               empty
);

  import ecs_pkg::*;

  localparam int aw = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;

  ecs_word_t     mem [fifo_depth];
  logic [aw-1:0] wr_ptr, wr_ptr_nxt;
  logic [aw-1:0] rd_ptr, rd_ptr_nxt;
  logic [aw:0]   count;        // occupancy
  logic [aw:0]   count_left;   // occupancy after this cycle's read
  logic          do_rd;

  assign do_rd      = rd & ~empty;
  assign empty      = (count == '0);
  assign count_left = count - {{aw{1'b0}}, do_rd};
  assign wr_ptr_nxt = (wr_ptr == aw'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
  assign rd_ptr_nxt = (rd_ptr == aw'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      dout   <= '0;
    end else begin
      if (wr) wr_ptr <= wr_ptr_nxt;
      if (do_rd) rd_ptr <= rd_ptr_nxt;
      count <= count_left + {{aw{1'b0}}, wr};
      if (wr && count_left == '0) begin
        dout <= din;               // write into an empty fifo goes straight to the head
      end else if (do_rd && count_left != '0) begin
        dout <= mem[rd_ptr_nxt];   // next stored word moves up
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr) mem[wr_ptr] <= din;
  end

endmodule

`default_nettype wire

//--- source/ecs_yuv_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module ecs_yuv_arbiter (
  input  logic               clk,
  input  logic               rstn,
  input  logic               y_empty,
  input  logic               u_empty,
  input  logic               v_empty,
  input  ecs_pkg::ecs_word_t y_head,
  input  ecs_pkg::ecs_word_t u_head,
  input  ecs_pkg::ecs_word_t v_head,
  output logic               y_rd,       // pop pulses, one per word sent
  output logic               u_rd,
  output logic               v_rd,
  output logic               out_valid,  // word is taken in this cycle
  output ecs_pkg::ecs_word_t out_word
);

  import ecs_pkg::*;

  chan_sel_t sel;        // channel whose segment is going out
  logic      sel_empty;

  // ----------------------------------------------------------
  // output mux
  // ----------------------------------------------------------
  always_comb begin
    case (sel)
      chan_u: begin
        sel_empty = u_empty;
        out_word  = u_head;
      end
      chan_v: begin
        sel_empty = v_empty;
        out_word  = v_head;
      end
      default: begin
        sel_empty = y_empty;
        out_word  = y_head;
      end
    endcase
  end

  assign out_valid = ~sel_empty;
  assign y_rd      = out_valid & (sel == chan_y);
  assign u_rd      = out_valid & (sel == chan_u);
  assign v_rd      = out_valid & (sel == chan_v);

  // rotate once the eob word of the segment has left
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      sel <= chan_y;
    end else if (out_valid && out_word.eob) begin
      sel <= next_chan(sel);
    end
  end

endmodule

`default_nettype wire

//--- include/ecs_defs.svh
`ifndef ECS_DEFS_SVH
`define ECS_DEFS_SVH
// padding fills are all ones, sized from WORD_W, TAIL_W and BUF_W in ecs_pkg
`define ECS_RULER "------------------------------"
`define ECS_TAG(name) {`ECS_RULER, " ", name, " ", `ECS_RULER}
`endif

//--- test/ecs_merge_chk.sv
`timescale 1ns/1ps
`default_nettype none

`include "ecs_defs.svh"

module ecs_merge_chk (
  input logic               clk,
  input logic               rstn,
  input logic               out_valid,
  input ecs_pkg::ecs_word_t out_word
);

  import ecs_pkg::*;

  // ----------------------------------------------------------
  // output protocol
  // ----------------------------------------------------------
  a_known : assert property (@(posedge clk) disable iff (!rstn)
    !$isunknown({out_valid, out_word}))
    else $error("%s", `ECS_TAG("out_valid or out_word unknown"));

  // an empty word never goes out
  a_len_nonzero : assert property (@(posedge clk) disable iff (!rstn)
    out_valid |-> (out_word.len != '0))
    else $error("%s", `ECS_TAG("word with zero length"));

  // only the last word of a segment may be short
  a_full_unless_eob : assert property (@(posedge clk) disable iff (!rstn)
    (out_valid && !out_word.eob) |-> (out_word.len == WLEN_W'(WORD_W)))
    else $error("%s", `ECS_TAG("short word without eob"));

endmodule

bind ecs_merge ecs_merge_chk chk_i (
  .clk       (clk),
  .rstn      (rstn),
  .out_valid (out_valid),
  .out_word  (out_word)
);

`default_nettype wire

//--- test/ecs_merge_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ecs_merge_tb;

  import ecs_pkg::*;

  localparam string trace_path = "test/ecs_merge_trace.txt";
  localparam int    drain_limit = 400;  // cycles allowed for the output to catch up

  logic      clk;
  logic      rstn;
  logic      y_valid, u_valid, v_valid;
  huff_sym_t y_sym, u_sym, v_sym;
  logic      out_valid;
  ecs_word_t out_word;

  // one {valid, symbol} stimulus entry per cycle
  logic [33:0] y_in[$], u_in[$], v_in[$];
  // expected words and test names per channel
  ecs_word_t   exp_y[$], exp_u[$], exp_v[$];
  string       name_y[$], name_u[$], name_v[$];
  int          cur_chan;   // follows the y -> u -> v rotation

  ecs_merge #(
    .fifo_depth (8)
  ) ecs_merge_i (
    .clk       (clk),
    .rstn      (rstn),
    .y_valid   (y_valid),
    .u_valid   (u_valid),
    .v_valid   (v_valid),
    .y_sym     (y_sym),
    .u_sym     (u_sym),
    .v_sym     (v_sym),
    .out_valid (out_valid),
    .out_word  (out_word)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("** FAIL **");
    $fatal(1);
  endtask

  // right aligned trace bits -> left aligned code padded with ones
  function automatic logic [33:0] make_sym(logic [63:0] bits, int len, int eob);
    huff_sym_t   s;
    logic [26:0] ones;
    ones   = '1;
    s.code = (bits[26:0] << (HUFF_W - len)) | (ones >> len);
    s.len  = len[HLEN_W-1:0];
    s.eob  = (eob != 0);
    return {(len != 0), s};
  endfunction

  // ----------------------------------------------------------
  // trace reader
  // ----------------------------------------------------------
  task automatic read_trace();
    int          fd;
    int          n;
    int          yl, ye, ul, ue, vl, ve, ch, eob, len, cnt;
    logic [63:0] yc, uc, vc, code;
    string       kind, tname, rest;
    ecs_word_t   w;
    fd = $fopen(trace_path, "r");
    assert (fd != 0) else stop_on_error("cannot open the trace file");
    while (!$feof(fd)) begin
      n = $fscanf(fd, "%s", kind);
      if (n != 1) break;
      if (kind[0] == "#") begin
        n = $fgets(rest, fd);  // comment line
      end else if (kind == "idle") begin
        n = $fscanf(fd, "%d", cnt);
        repeat (cnt) begin
          y_in.push_back('0);
          u_in.push_back('0);
          v_in.push_back('0);
        end
      end else if (kind == "in") begin
        n = $fscanf(fd, "%h %d %d %h %d %d %h %d %d", yc, yl, ye, uc, ul, ue, vc, vl, ve);
        assert (n == 9) else stop_on_error("malformed input line in the trace");
        y_in.push_back(make_sym(yc, yl, ye));
        u_in.push_back(make_sym(uc, ul, ue));
        v_in.push_back(make_sym(vc, vl, ve));
      end else if (kind == "exp") begin
        n = $fscanf(fd, "%s %d %d %d %h", tname, ch, eob, len, code);
        assert (n == 5) else stop_on_error("malformed expected line in the trace");
        w.eob  = (eob != 0);
        w.len  = len[WLEN_W-1:0];
        w.code = code;
        case (ch)
          0: begin
            exp_y.push_back(w);
            name_y.push_back(tname);
          end
          1: begin
            exp_u.push_back(w);
            name_u.push_back(tname);
          end
          default: begin
            exp_v.push_back(w);
            name_v.push_back(tname);
          end
        endcase
      end else begin
        stop_on_error({"unknown line kind in the trace: ", kind});
      end
    end
    $fclose(fd);
  endtask

  // ----------------------------------------------------------
  // output monitor samples mid cycle where out_word is settled
  // ----------------------------------------------------------
  initial begin
    ecs_word_t want;
    string     tname;
    bit        have;
    forever begin
      @(negedge clk);
      if (rstn && out_valid) begin
        case (cur_chan)
          0: have = (exp_y.size() > 0);
          1: have = (exp_u.size() > 0);
          default: have = (exp_v.size() > 0);
        endcase
        assert (have) else
          stop_on_error($sformatf("output word on channel %0d with none expected", cur_chan));
        case (cur_chan)
          0: begin
            want  = exp_y.pop_front();
            tname = name_y.pop_front();
          end
          1: begin
            want  = exp_u.pop_front();
            tname = name_u.pop_front();
          end
          default: begin
            want  = exp_v.pop_front();
            tname = name_v.pop_front();
          end
        endcase
        assert (out_word === want) else
          stop_on_error($sformatf(
            "error %s chan %0d expected eob=%0d len=%0d code=%h actual eob=%0d len=%0d code=%h",
            tname, cur_chan, want.eob, want.len, want.code,
            out_word.eob, out_word.len, out_word.code));
        if (out_word.eob) cur_chan = (cur_chan == 2) ? 0 : cur_chan + 1;  // next segment
      end
    end
  end

  // ----------------------------------------------------------
  // stimulus
  // ----------------------------------------------------------
  initial begin
    logic [33:0] y_e, u_e, v_e;
    int          waited;
    rstn       = 1'b0;
    y_valid    = 1'b0;
    u_valid    = 1'b0;
    v_valid    = 1'b0;
    y_sym      = '0;
    u_sym      = '0;
    v_sym      = '0;
    cur_chan   = 0;
    read_trace();
    repeat (10) @(posedge clk);
    @(negedge clk);
    rstn = 1'b1;
    while (y_in.size() > 0) begin
      @(negedge clk);
      y_e = y_in.pop_front();
      u_e = u_in.pop_front();
      v_e = v_in.pop_front();
      {y_valid, y_sym} = y_e;
      {u_valid, u_sym} = u_e;
      {v_valid, v_sym} = v_e;
    end
    @(negedge clk);
    y_valid = 1'b0;
    u_valid = 1'b0;
    v_valid = 1'b0;
    // wait for every expected word to come out
    waited = 0;
    while (exp_y.size() + exp_u.size() + exp_v.size() > 0) begin
      @(negedge clk);
      waited++;
      assert (waited < drain_limit) else
        stop_on_error("timeout waiting for the expected output words");
    end
    repeat (8) @(negedge clk);  // catch stray extra words
    $display("** PASS **");
    $finish;
  end

endmodule

`default_nettype wire

//--- test/ecs_merge_trace.txt
# in: y u v, each as bits (hex, right aligned) len (dec, 0 = no symbol) eob
# exp: test chan (0=y 1=u 2=v) eob len code (hex, 64 bit msb first)
in a 4 0 0 0 0 0 0 0
in 12 8 0 0 0 0 0 0 0
in 3 4 1 0 0 0 0 0 0
exp t1_short 0 1 16 a123ffffffffffff
idle 4
in 0 0 0 abcdef 24 0 0 0 0
in 0 0 0 012345 24 0 0 0 0
in 0 0 0 6789ab 24 0 0 0 0
in 0 0 0 cd 8 1 0 0 0
exp t2_cross 1 0 64 abcdef0123456789
exp t2_cross 1 1 16 abcdffffffffffff
idle 4
in 0 0 0 0 0 0 111111 24 0
in 0 0 0 0 0 0 222222 24 0
in 0 0 0 0 0 0 333333 24 1
exp t3_tail 2 0 64 1111112222223333
exp t3_tail 2 1 8 33ffffffffffffff
idle 4
in 0123 16 0 0 0 0 0 0 0
in 4567 16 0 0 0 0 0 0 0
in 89ab 16 0 0 0 0 0 0 0
in cdef 16 1 0 0 0 0 0 0
exp t4_exact 0 1 64 0123456789abcdef
idle 4
in fed 12 0 1 27 0 0 1 1
in 0 4 1 10 5 1 5 3 1
in 55 8 0 12345 20 0 0 0 0
in 66 8 1 6789a 20 0 0 0 0
in 0 0 0 bcdef 20 0 0 0 0
in 0 0 0 13579 20 1 0 0 0
exp t5_all 0 1 16 fed0ffffffffffff
exp t5_all 1 1 32 00000030ffffffff
exp t5_all 2 1 1 7fffffffffffffff
exp t6_back 0 1 16 5566ffffffffffff
exp t6_back 1 0 64 123456789abcdef1
exp t6_back 1 1 16 3579ffffffffffff
exp t6_back 2 1 3 bfffffffffffffff
idle 4
